/* src/base_cfg_pkg.sv */
// joystick frame, switch, status and sound definitions for the board base
// frame is 15 slots, two players of six active-low buttons on one serial line
package base_cfg_pkg;

    typedef logic [4:0]  slot_t;     // slot index in a joystick frame
    typedef logic [3:0]  joy_bit_t;  // bit index in a player word
    typedef logic [15:0] joy_word_t; // active high, 1 = pressed
    typedef logic [31:0] status_t;   // status word to the core
    typedef logic [15:0] pcm_t;      // one sound sample

    typedef struct packed {
        logic  strobe; // one clk_sys cycle per slot
        slot_t slot;   // slot sampled at this strobe
    } joy_slot_t;

    typedef struct packed {
        logic test;      // bit 3
        logic flip;      // bit 2
        logic scanlines; // bit 1
        logic native;    // bit 0, scan doubler off
    } vgactrl_t;

    localparam int unsigned JOY_SLOTS = 15;
    localparam slot_t SLOT_LAST     = slot_t'(JOY_SLOTS - 1);
    localparam slot_t SLOT_LOAD     = 5'd0; // chain latches its inputs here
    localparam slot_t SLOT_P1_FIRST = 5'd2;
    localparam slot_t SLOT_P2_FIRST = 5'd8;
    localparam slot_t JOY_BTNS      = 5'd6; // slots per player

    localparam joy_bit_t JOY_RIGHT = 4'd0;
    localparam joy_bit_t JOY_LEFT  = 4'd1;
    localparam joy_bit_t JOY_DOWN  = 4'd2;
    localparam joy_bit_t JOY_UP    = 4'd3;
    localparam joy_bit_t JOY_FIRE1 = 4'd4;
    localparam joy_bit_t JOY_FIRE2 = 4'd5;
    localparam joy_bit_t JOY_FIRE3 = 4'd6; // only set by the fire remap

    localparam int unsigned STATUS_SCANLINES = 3;
    localparam int unsigned STATUS_TEST      = 6;
    localparam int unsigned STATUS_FLIP      = 12;

    // slot offset within a player's group to word bit
    function automatic joy_bit_t slot_to_bit(input slot_t ofs);
        case (ofs)
            5'd0:    return JOY_FIRE2;
            5'd1:    return JOY_FIRE1;
            5'd2:    return JOY_RIGHT;
            5'd3:    return JOY_LEFT;
            5'd4:    return JOY_DOWN;
            default: return JOY_UP;
        endcase
    endfunction

endpackage

/* src/video_pkg.sv */
// video path types, 6 bits per colour as on the board resistor DAC
// sync polarity is passed through as given by the source
package video_pkg;

    typedef logic [5:0] color6_t; // one output colour

    typedef struct packed {
        color6_t r;
        color6_t g;
        color6_t b;
    } rgb6_t;

    typedef struct packed {
        logic hs;
        logic vs;
    } sync_t;

    typedef struct packed {
        rgb6_t rgb;  // 18 bits
        sync_t sync; // 2 bits
    } video_out_t;

endpackage

/* src/base_ctrl.sv */
// joystick chain timing and board switch decode
// one slot lasts 2**JOY_DIV_BITS clk_sys cycles, joy_clk is its top divider bit
// joy_clk only goes to the pin, nothing inside is clocked by it
module base_ctrl
    import base_cfg_pkg::*;
#(
    parameter int unsigned JOY_DIV_BITS = 8
) (
    input  logic       clk_sys,
    input  logic       reset,
    input  logic [3:0] vgactrl_en,
    output logic       joy_clk,
    output logic       joy_load,
    output joy_slot_t  joy_slot,
    output logic       native_video,
    output status_t    status
);

    // divider value in the cycle after the top bit rises
    localparam logic [JOY_DIV_BITS-1:0] DIV_RISE =
        JOY_DIV_BITS'(1) << (JOY_DIV_BITS - 1);

    logic [JOY_DIV_BITS-1:0] div_cnt; // free running
    slot_t                   slot_cnt; // slot sampled at the next strobe
    logic                    strobe;
    vgactrl_t                vga_q;   // registered board switches

    assign joy_clk = div_cnt[JOY_DIV_BITS-1]; // low after reset
    assign strobe  = (div_cnt == DIV_RISE);   // first cycle of joy_clk high

    assign joy_slot = '{strobe: strobe, slot: slot_cnt};

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            div_cnt  <= '0;
            slot_cnt <= '0;
            joy_load <= 1'b1; // chain shifting, not loading
        end else begin
            div_cnt <= div_cnt + JOY_DIV_BITS'(1);
            if (strobe) begin
                slot_cnt <= (slot_cnt == SLOT_LAST) ? '0 : slot_cnt + slot_t'(1);
                // low for one slot after the load slot strobe
                joy_load <= (slot_cnt != SLOT_LOAD);
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            vga_q <= '0;
        end else begin
            vga_q <= vgactrl_en; // switches are slow, one stage is enough
        end
    end

    assign native_video = vga_q.native;

    always_comb begin
        status                   = '0;              // unused bits stay low
        status[STATUS_SCANLINES] = vga_q.scanlines; // scanline effect
        status[STATUS_TEST]      = vga_q.test;      // core test mode
        status[STATUS_FLIP]      = vga_q.flip;      // screen flip
    end

    // counter must wrap before leaving the frame
    slot_in_frame_a: assert property (@(posedge clk_sys) disable iff (reset)
        slot_cnt <= SLOT_LAST);

    // receiver takes one bit per strobe, back to back pulses would double sample
    strobe_single_a: assert property (@(posedge clk_sys) disable iff (reset)
        strobe |=> !strobe);

endmodule

/* src/joy_serial_rx.sv */
// serial button capture for two players
// joy_data must be stable in the strobe cycle, buttons are active low on the line
// FIRE_REMAP turns one fire button plus left/right into three fire bits
module joy_serial_rx
    import base_cfg_pkg::*;
#(
    parameter bit FIRE_REMAP = 1'b0
) (
    input  logic      clk_sys,
    input  logic      reset,
    input  joy_slot_t joy_slot,
    input  logic      joy_data,
    output joy_word_t joystick1,
    output joy_word_t joystick2
);

    joy_word_t raw1; // player 1 line levels, 1 = released
    joy_word_t raw2; // player 2 line levels
    slot_t     ofs1; // offset into player 1 group
    slot_t     ofs2; // offset into player 2 group

    // slots below the group wrap to large values and fail the range check
    assign ofs1 = joy_slot.slot - SLOT_P1_FIRST;
    assign ofs2 = joy_slot.slot - SLOT_P2_FIRST;

    // line levels to the active-high player word
    function automatic joy_word_t to_player(input joy_word_t raw);
        joy_word_t pressed;
        joy_word_t w;
        pressed = ~raw;
        if (FIRE_REMAP) begin
            w            = '0; // fire2 dropped
            w[JOY_RIGHT] = pressed[JOY_RIGHT];
            w[JOY_LEFT]  = pressed[JOY_LEFT];
            w[JOY_DOWN]  = pressed[JOY_DOWN];
            w[JOY_UP]    = pressed[JOY_UP];
            // fire aimed left
            w[JOY_FIRE1] = pressed[JOY_FIRE1] & pressed[JOY_LEFT] & ~pressed[JOY_RIGHT];
            // fire straight ahead
            w[JOY_FIRE2] = pressed[JOY_FIRE1] & ~pressed[JOY_LEFT] & ~pressed[JOY_RIGHT];
            // fire aimed right
            w[JOY_FIRE3] = pressed[JOY_FIRE1] & pressed[JOY_RIGHT] & ~pressed[JOY_LEFT];
        end else begin
            w = pressed; // unwritten raw bits stay 1, so upper bits read 0
        end
        return w;
    endfunction

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            raw1 <= '1; // all released
            raw2 <= '1;
        end else if (joy_slot.strobe) begin
            if (ofs1 < JOY_BTNS) begin
                raw1[slot_to_bit(ofs1)] <= joy_data;
            end
            if (ofs2 < JOY_BTNS) begin
                raw2[slot_to_bit(ofs2)] <= joy_data;
            end
        end
    end

    // words follow the raw bits one cycle later, every cycle
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            joystick1 <= '0;
            joystick2 <= '0;
        end else begin
            joystick1 <= to_player(raw1);
            joystick2 <= to_player(raw2);
        end
    end

endmodule

/* src/video_out_mux.sv */
// final video select for the 6-bit VGA/SCART output, one register stage
// native mode drives composite sync on hs and holds vs high for SCART RGB
// scan-doubled video passes as given, colour width COLORW from 3 to 8
module video_out_mux
    import video_pkg::*;
#(
    parameter int COLORW = 4
) (
    input  logic              clk_sys,
    input  logic              reset,
    input  logic              native_video,
    input  logic [COLORW-1:0] game_r,
    input  logic [COLORW-1:0] game_g,
    input  logic [COLORW-1:0] game_b,
    input  sync_t             game_sync,
    input  rgb6_t             scan2x_rgb,
    input  sync_t             scan2x_sync,
    output video_out_t        video_out
);

    video_out_t nxt;   // output before the register
    logic       csync; // composite of game hs and vs

    // msb first, repeat the colour for narrow widths, drop lsbs for wide ones
    function automatic color6_t widen(input logic [COLORW-1:0] c);
        color6_t w;
        for (int i = 0; i < 6; i++) begin
            w[5 - i] = c[COLORW - 1 - (i % COLORW)];
        end
        return w;
    endfunction

    // inverted hs equal to inverted vs
    assign csync = ~(game_sync.hs ^ game_sync.vs);

    always_comb begin
        if (native_video) begin
            nxt.rgb.r   = widen(game_r);
            nxt.rgb.g   = widen(game_g);
            nxt.rgb.b   = widen(game_b);
            nxt.sync.hs = csync;
            nxt.sync.vs = 1'b1; // selects RGB on the SCART cable
        end else begin
            nxt.rgb  = scan2x_rgb;
            nxt.sync = scan2x_sync;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            video_out <= '0;
        end else begin
            video_out <= nxt;
        end
    end

    colorw_range_a: assert property (@(posedge clk_sys)
        COLORW >= 3 && COLORW <= 8);

endmodule

/* src/sigma_delta_dac.sv */
// first-order 1-bit sigma-delta, one sound channel
// density of ones is level/65536, needs an external RC low pass
// SIGNED_SND set means two's complement input, else offset binary
module sigma_delta_dac
    import base_cfg_pkg::*;
#(
    parameter bit SIGNED_SND = 1'b0
) (
    input  logic clk_sys,
    input  logic reset,
    input  pcm_t pcm,
    output logic dac_out
);

    pcm_t        level; // offset binary level
    pcm_t        acc;   // error accumulator
    logic [16:0] sum;   // carry out is the pulse

    assign level = {pcm[15] ^ SIGNED_SND, pcm[14:0]}; // sign flip to offset binary
    assign sum   = {1'b0, acc} + {1'b0, level};

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            acc     <= '0;
            dac_out <= 1'b0;
        end else begin
            acc     <= sum[15:0]; // remainder carried into the next sample
            dac_out <= sum[16];
        end
    end

endmodule

/* src/cyclone_base.sv */
// board-side base of the arcade core, everything on clk_sys
// JOY_DIV_BITS sets the joystick slot length, 8 on the board
// STEREO cleared copies the left pulse stream to the right output
module cyclone_base
    import base_cfg_pkg::*, video_pkg::*;
#(
    parameter int          COLORW       = 4,
    parameter int unsigned JOY_DIV_BITS = 8,
    parameter bit          SIGNED_SND   = 1'b1,
    parameter bit          STEREO       = 1'b0,
    parameter bit          FIRE_REMAP   = 1'b0
) (
    input  logic              clk_sys,
    input  logic              reset,
    input  logic [3:0]        vgactrl_en,
    input  logic              joy_data,
    input  logic [COLORW-1:0] game_r,
    input  logic [COLORW-1:0] game_g,
    input  logic [COLORW-1:0] game_b,
    input  logic              game_hs,
    input  logic              game_vs,
    input  logic [5:0]        scan2x_r,
    input  logic [5:0]        scan2x_g,
    input  logic [5:0]        scan2x_b,
    input  logic              scan2x_hs,
    input  logic              scan2x_vs,
    input  pcm_t              snd_left,
    input  pcm_t              snd_right,
    output logic              joy_clk,
    output logic              joy_load,
    output joy_word_t         joystick1,
    output joy_word_t         joystick2,
    output status_t           status,
    output logic              scan2x_enb,
    output logic [5:0]        video_r,
    output logic [5:0]        video_g,
    output logic [5:0]        video_b,
    output logic              video_hs,
    output logic              video_vs,
    output logic              snd_left_out,
    output logic              snd_right_out
);

    joy_slot_t  joy_slot;     // strobe and slot to the receiver
    logic       native_video; // scan doubler off
    sync_t      game_sync;
    sync_t      scan2x_sync;
    rgb6_t      scan2x_rgb;
    video_out_t vid;

    assign game_sync   = '{hs: game_hs, vs: game_vs};
    assign scan2x_sync = '{hs: scan2x_hs, vs: scan2x_vs};
    assign scan2x_rgb  = '{r: scan2x_r, g: scan2x_g, b: scan2x_b};
    assign scan2x_enb  = native_video; // high disables the scan doubler

    base_ctrl #(.JOY_DIV_BITS(JOY_DIV_BITS)) u_base_ctrl (
        .clk_sys, .reset, .vgactrl_en, .joy_clk, .joy_load,
        .joy_slot, .native_video, .status
    );

    joy_serial_rx #(.FIRE_REMAP(FIRE_REMAP)) u_joy_serial_rx (
        .clk_sys, .reset, .joy_slot, .joy_data, .joystick1, .joystick2
    );

    video_out_mux #(.COLORW(COLORW)) u_video_out_mux (
        .clk_sys, .reset, .native_video, .game_r, .game_g, .game_b,
        .game_sync, .scan2x_rgb, .scan2x_sync, .video_out(vid)
    );

    assign video_r  = vid.rgb.r;
    assign video_g  = vid.rgb.g;
    assign video_b  = vid.rgb.b;
    assign video_hs = vid.sync.hs;
    assign video_vs = vid.sync.vs;

    sigma_delta_dac #(.SIGNED_SND(SIGNED_SND)) u_dac_left (
        .clk_sys, .reset, .pcm(snd_left), .dac_out(snd_left_out)
    );

    if (STEREO) begin : g_stereo
        sigma_delta_dac #(.SIGNED_SND(SIGNED_SND)) u_dac_right (
            .clk_sys, .reset, .pcm(snd_right), .dac_out(snd_right_out)
        );
    end else begin : g_mono
        assign snd_right_out = snd_left_out; // mono game, snd_right unused
    end

endmodule

/* testbench/tb_joy_chain.sv */
// model of the serial button chain for two players, buttons 1 = pressed
// latches while joy_load is low, then puts out one active-low bit per joy_clk rise
module tb_joy_chain
    import base_cfg_pkg::*;
(
    input  logic       joy_clk,
    input  logic       joy_load,
    input  logic [5:0] p1_btn,   // slot order fire2, fire1, right, left, down, up
    input  logic [5:0] p2_btn,
    output logic       joy_data
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DRIVE_DELAY = 1; // after the joy_clk rise

    logic [5:0] held1; // buttons taken at load
    logic [5:0] held2;

    // line level for one slot, unused slots idle high
    function automatic logic slot_level(input int slot);
        logic [2:0] ofs;
        if (slot >= int'(SLOT_P1_FIRST) && slot < int'(SLOT_P2_FIRST)) begin
            ofs = 3'(slot - int'(SLOT_P1_FIRST));
            return ~held1[ofs];
        end else if (slot >= int'(SLOT_P2_FIRST) && slot < int'(SLOT_P2_FIRST) + 6) begin
            ofs = 3'(slot - int'(SLOT_P2_FIRST));
            return ~held2[ofs];
        end
        return 1'b1;
    endfunction

    initial begin : shift_out
        joy_data = 1'b1; // idle line
        held1    = '0;
        held2    = '0;
        forever begin
            @(negedge joy_load);
            held1 = p1_btn; // parallel load
            held2 = p2_btn;
            @(posedge joy_load); // rises as slot 1 is taken, next clock rise is slot 2
            for (int slot = int'(SLOT_P1_FIRST); slot < int'(JOY_SLOTS); slot++) begin
                @(posedge joy_clk);
                #DRIVE_DELAY;
                joy_data = slot_level(slot);
            end
        end
    end

endmodule

/* testbench/tb_cyclone_base.sv */
// testbench for the board base with the joystick slot shortened to 8 clk_sys cycles
// stereo build with signed samples and no fire remap
module tb_cyclone_base
    import base_cfg_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int COLORW        = 4;
    localparam int JOY_DIV_BITS  = 3;
    localparam int CLK_PERIOD    = 10;
    localparam int DRIVE_DELAY   = 1;
    localparam int RST_CYCLES    = 10;
    localparam int SLOT_CYCLES   = 1 << JOY_DIV_BITS;
    localparam int FRAME_CYCLES  = int'(JOY_SLOTS) * SLOT_CYCLES;
    localparam int N_JOY         = 8;  // button sets
    localparam int N_VID         = 64; // cycles per video mode
    localparam int N_DAC         = 3;  // sample pairs
    localparam int DAC_CYCLES    = 4096;
    localparam int TEST_CYCLES   = RST_CYCLES + FRAME_CYCLES * (2 + 3 * N_JOY) + 16 * 3
                                 + 2 * (N_VID + 4) + N_DAC * (DAC_CYCLES + RST_CYCLES + 4);
    localparam int MARGIN_CYCLES = 500;

    logic              clk_sys, reset, joy_data;
    logic [3:0]        vgactrl_en;
    logic [COLORW-1:0] game_r, game_g, game_b;
    logic              game_hs, game_vs, scan2x_hs, scan2x_vs;
    logic [5:0]        scan2x_r, scan2x_g, scan2x_b;
    pcm_t              snd_left, snd_right;
    logic              joy_clk, joy_load, scan2x_enb;
    joy_word_t         joystick1, joystick2;
    status_t           status;
    logic [5:0]        video_r, video_g, video_b;
    logic              video_hs, video_vs, snd_left_out, snd_right_out;
    logic [5:0]        p1_btn, p2_btn;  // chain buttons in slot order
    logic              video_mode;      // 1 = native expected
    logic              video_check_en;
    logic              load_mon_en;

    cyclone_base #(
        .COLORW(COLORW), .JOY_DIV_BITS(JOY_DIV_BITS), .SIGNED_SND(1'b1),
        .STEREO(1'b1), .FIRE_REMAP(1'b0)
    ) i_cyclone_base (.*);

    tb_joy_chain u_joy_chain (.joy_clk, .joy_load, .p1_btn, .p2_btn, .joy_data);

    // slot-order buttons to player word
    function automatic joy_word_t expected_word(input logic [5:0] btn);
        joy_word_t w;
        w    = '0;
        w[0] = btn[2]; // right
        w[1] = btn[3]; // left
        w[2] = btn[4]; // down
        w[3] = btn[5]; // up
        w[4] = btn[1]; // fire1
        w[5] = btn[0]; // fire2
        return w;
    endfunction

    function automatic status_t expected_status(input logic [3:0] sw);
        status_t s;
        s     = '0;
        s[3]  = sw[1]; // scanlines
        s[12] = sw[2]; // flip
        s[6]  = sw[3]; // test mode
        return s;
    endfunction

    // narrow colours repeat their top bits and wide ones lose low bits
    function automatic logic [5:0] widen_ref(input logic [7:0] c);
        case (COLORW)
            3:       return {c[2:0], c[2:0]};
            4:       return {c[3:0], c[3:2]};
            5:       return {c[4:0], c[4]};
            6:       return c[5:0];
            7:       return c[6:1];
            default: return c[7:2];
        endcase
    endfunction

    function automatic logic csync_ref(input logic hs, input logic vs);
        return (!hs) == (!vs);
    endfunction

    // ones after n cycles from a cleared accumulator at an offset binary level
    function automatic int expected_ones(input pcm_t pcm, input int n);
        longint level;
        level = longint'({~pcm[15], pcm[14:0]});
        return int'((longint'(n) * level) >> 16);
    endfunction

    task automatic fail_stop(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            fail_stop($sformatf("FAIL at %0d ns: %s = %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_sys);
        #DRIVE_DELAY;
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_sys);
        #DRIVE_DELAY;
        reset = 1'b0;
    endtask

    // returns at the falling clk_sys edge where joy_load is first seen low again
    task automatic wait_load_fall();
        int   n;
        logic prev;
        logic fell;
        n    = 0;
        prev = joy_load;
        do begin
            @(negedge clk_sys);
            n++;
            assert (n <= 2 * FRAME_CYCLES) else fail_stop("joy_load stopped falling");
            fell = prev && !joy_load;
            prev = joy_load;
        end while (!fell);
    endtask

    task automatic drive_video_random();
        game_r    = COLORW'($urandom);
        game_g    = COLORW'($urandom);
        game_b    = COLORW'($urandom);
        game_hs   = 1'($urandom);
        game_vs   = 1'($urandom);
        scan2x_r  = 6'($urandom);
        scan2x_g  = 6'($urandom);
        scan2x_b  = 6'($urandom);
        scan2x_hs = 1'($urandom);
        scan2x_vs = 1'($urandom);
    endtask

    task automatic run_video(input logic mode);
        next_cycle();
        video_mode = mode;
        vgactrl_en = {3'b000, mode};
        next_cycle(); // switch register settles
        next_cycle();
        video_check_en = 1'b1;
        repeat (N_VID) begin
            drive_video_random();
            next_cycle();
        end
        video_check_en = 1'b0; // last value still checked at this negedge
    endtask

    task automatic run_dac(input pcm_t left, input pcm_t right);
        int ones_l;
        int ones_r;
        ones_l    = 0;
        ones_r    = 0;
        snd_left  = left;
        snd_right = right;
        apply_reset(); // accumulators from zero
        repeat (DAC_CYCLES) begin
            @(posedge clk_sys);
            @(negedge clk_sys);
            ones_l += int'(snd_left_out);
            ones_r += int'(snd_right_out);
        end
        check_value("snd_left_out ones", 32'(ones_l), 32'(expected_ones(left, DAC_CYCLES)));
        check_value("snd_right_out ones", 32'(ones_r), 32'(expected_ones(right, DAC_CYCLES)));
    endtask

    initial begin : clock_gen
        clk_sys = 1'b0;
        forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
    end

    initial begin : watchdog
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        fail_stop("timeout, the tests did not finish in the expected time");
    end

    // expected video taken at the clock edge and the output compared half a cycle later
    initial begin : video_compare
        logic       armed;
        logic [5:0] exp_r, exp_g, exp_b;
        logic       exp_hs, exp_vs;
        forever begin
            @(posedge clk_sys);
            armed = video_check_en;
            if (video_mode) begin
                exp_r  = widen_ref(8'(game_r));
                exp_g  = widen_ref(8'(game_g));
                exp_b  = widen_ref(8'(game_b));
                exp_hs = csync_ref(game_hs, game_vs);
                exp_vs = 1'b1; // held for SCART RGB
            end else begin
                exp_r  = scan2x_r;
                exp_g  = scan2x_g;
                exp_b  = scan2x_b;
                exp_hs = scan2x_hs;
                exp_vs = scan2x_vs;
            end
            @(negedge clk_sys);
            if (armed) begin
                check_value("video_r", 32'(video_r), 32'(exp_r));
                check_value("video_g", 32'(video_g), 32'(exp_g));
                check_value("video_b", 32'(video_b), 32'(exp_b));
                check_value("video_hs", 32'(video_hs), 32'(exp_hs));
                check_value("video_vs", 32'(video_vs), 32'(exp_vs));
            end
        end
    end

    // load low for one slot and high for the other fourteen
    initial begin : load_monitor
        int   run;
        logic prev;
        logic seen;
        run  = 0;
        prev = 1'b1;
        seen = 1'b0;
        forever begin
            @(negedge clk_sys);
            if (!load_mon_en) begin
                seen = 1'b0; // first run after enable is partial
                prev = joy_load;
            end else if (joy_load == prev) begin
                run++;
            end else begin
                if (seen && prev) begin
                    check_value("joy_load high cycles", 32'(run), 32'(FRAME_CYCLES - SLOT_CYCLES));
                end
                if (seen && !prev) begin
                    check_value("joy_load low cycles", 32'(run), 32'(SLOT_CYCLES));
                end
                seen = 1'b1;
                run  = 1;
                prev = joy_load;
            end
        end
    end

    initial begin : stimulus
        int   n;
        pcm_t left;
        pcm_t right;
        void'($urandom(32'hf2df));
        reset          = 1'b1;
        vgactrl_en     = 4'h0;
        video_mode     = 1'b0;
        video_check_en = 1'b0;
        load_mon_en    = 1'b0;
        snd_left       = '0;
        snd_right      = '0;
        drive_video_random();
        p1_btn = 6'($urandom) | 6'h01; // words stay zero even with buttons pressed
        p2_btn = 6'($urandom) | 6'h20;
        apply_reset();
        load_mon_en = 1'b1;

        // reset state and zero words up to the first load
        @(negedge clk_sys);
        check_value("joy_load", 32'(joy_load), 32'd1);
        check_value("joy_clk", 32'(joy_clk), 32'd0);
        n = 0;
        while (joy_load) begin
            check_value("joystick1", 32'(joystick1), 32'd0);
            check_value("joystick2", 32'(joystick2), 32'd0);
            @(negedge clk_sys);
            n++;
            assert (n <= FRAME_CYCLES) else fail_stop("joy_load did not fall after reset");
        end

        repeat (N_JOY) begin
            next_cycle();
            p1_btn = 6'($urandom);
            p2_btn = 6'($urandom);
            wait_load_fall(); // chain latches the new set
            wait_load_fall(); // that frame is fully shifted in
            check_value("joystick1", 32'(joystick1), 32'(expected_word(p1_btn)));
            check_value("joystick2", 32'(joystick2), 32'(expected_word(p2_btn)));
        end

        for (int v = 0; v < 16; v++) begin
            next_cycle();
            vgactrl_en = 4'(v);
            @(posedge clk_sys); // switch register
            @(negedge clk_sys);
            check_value("status", status, expected_status(4'(v)));
            check_value("scan2x_enb", 32'(scan2x_enb), 32'(v & 1));
        end

        run_video(1'b1);
        run_video(1'b0);

        load_mon_en = 1'b0; // dac resets restart the divider
        repeat (N_DAC) begin
            next_cycle();
            left  = pcm_t'($urandom);
            right = pcm_t'($urandom);
            while (expected_ones(right, DAC_CYCLES) == expected_ones(left, DAC_CYCLES)) begin
                right = pcm_t'($urandom); // counts differ so a swap shows
            end
            run_dac(left, right);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

/* src.f */
src/base_cfg_pkg.sv
src/video_pkg.sv
src/base_ctrl.sv
src/joy_serial_rx.sv
src/video_out_mux.sv
src/sigma_delta_dac.sv
src/cyclone_base.sv
testbench/tb_joy_chain.sv
testbench/tb_cyclone_base.sv

/* Makefile */
# Verilator build, run, lint and clean for the board base testbench
VERILATOR ?= verilator
TOP       ?= tb_cyclone_base
FLIST     ?= src.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
LINTFLAGS ?= -Wall
PASS_MSG  ?= TEST OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
